/* common/lsq_pkg.sv */
package lsq_pkg;

    // lane and table sizes
    localparam int ways        = 2;
    localparam int sq_entries  = 8;
    localparam int rob_entries = 32;
    localparam int prf_entries = 64;

    // datapath widths
    localparam int addr_w    = 16;
    localparam int data_w    = 64;
    localparam int mem_bytes = 256;

    typedef logic [addr_w-1:0]                 addr_t;
    typedef logic [data_w-1:0]                 data_t;
    typedef logic [$clog2(rob_entries)-1:0]    rob_idx_t;
    typedef logic [$clog2(prf_entries)-1:0]    prf_tag_t;
    typedef logic [$clog2(sq_entries)-1:0]     sq_ptr_t;
    // one extra bit so a count of 8 fits
    typedef logic [$clog2(sq_entries):0]       sq_count_t;
    typedef logic [$clog2(mem_bytes)-1:0]      mem_idx_t;

    // access size encoding
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t size_byte   = 2'h0;
    localparam mem_size_t size_half   = 2'h1;
    localparam mem_size_t size_word   = 2'h2;
    localparam mem_size_t size_double = 2'h3;

    // one store queue slot
    typedef struct packed {
        logic      valid;
        mem_size_t size;
        rob_idx_t  rob_idx;
        prf_tag_t  tag;
        data_t     data;
        logic      data_valid;
        addr_t     addr;
        logic      addr_valid;
    } sq_entry_t;

endpackage

/* common/sq_dispatch_if.sv */
`timescale 1ns/100ps

interface sq_dispatch_if import lsq_pkg::*; ();

    // one slot per dispatch lane, enabled lanes packed low
    logic      [ways-1:0] enable;
    mem_size_t [ways-1:0] size;
    rob_idx_t  [ways-1:0] rob_idx;
    prf_tag_t  [ways-1:0] tag;
    data_t     [ways-1:0] data;
    logic      [ways-1:0] data_valid;

    modport dispatch (
        output enable,
        output size,
        output rob_idx,
        output tag,
        output data,
        output data_valid
    );

    modport queue (
        input enable,
        input size,
        input rob_idx,
        input tag,
        input data,
        input data_valid
    );

endinterface

/* common/dcache_write_if.sv */
`timescale 1ns/100ps

interface dcache_write_if import lsq_pkg::*; ();

    // single retiring store, never refused
    logic      en;
    addr_t     addr;
    data_t     data;
    mem_size_t size;

    modport queue (
        output en,
        output addr,
        output data,
        output size
    );

    modport mem (
        input en,
        input addr,
        input data,
        input size
    );

endinterface

/* rtl/store_dispatch.sv */
`timescale 1ns/100ps

module store_dispatch import lsq_pkg::*; (
    input  logic      [ways-1:0] req_valid,
    input  mem_size_t [ways-1:0] req_size,
    input  rob_idx_t  [ways-1:0] req_rob_idx,
    input  prf_tag_t  [ways-1:0] req_tag,
    input  data_t     [ways-1:0] req_data,
    input  logic      [ways-1:0] req_data_ready,
    input  logic      [ways-1:0] cdb_valid,
    input  prf_tag_t  [ways-1:0] cdb_tag,
    input  data_t     [ways-1:0] cdb_data,
    input  sq_count_t            num_free,
    output logic                 stall,
    sq_dispatch_if.dispatch      disp
);

    sq_count_t        req_count;
    data_t [ways-1:0] byp_data;
    logic  [ways-1:0] byp_ready;

    always_comb begin
        req_count = '0;
        for (int i = 0; i < ways; i++) begin
            req_count = req_count + sq_count_t'(req_valid[i]);
        end
    end

    // whole group waits if it does not fit
    assign stall = req_count > num_free;

    // catch a broadcast landing in the dispatch cycle
    always_comb begin
        for (int i = 0; i < ways; i++) begin
            byp_data[i]  = req_data[i];
            byp_ready[i] = req_data_ready[i];
            for (int j = 0; j < ways; j++) begin
                if (!req_data_ready[i] && cdb_valid[j] && cdb_tag[j] == req_tag[i]) begin
                    byp_data[i]  = cdb_data[j];
                    byp_ready[i] = 1'b1;
                end
            end
        end
    end

    // compact valid requests into the low lanes
    always_comb begin
        int slot;
        slot            = 0;
        disp.enable     = '0;
        disp.size       = '0;
        disp.rob_idx    = '0;
        disp.tag        = '0;
        disp.data       = '0;
        disp.data_valid = '0;
        for (int i = 0; i < ways; i++) begin
            if (req_valid[i]) begin
                disp.enable[slot]     = !stall;
                disp.size[slot]       = req_size[i];
                disp.rob_idx[slot]    = req_rob_idx[i];
                disp.tag[slot]        = req_tag[i];
                disp.data[slot]       = byp_data[i];
                disp.data_valid[slot] = byp_ready[i];
                slot = slot + 1;
            end
        end
    end

endmodule

/* store_queue/store_queue.sv */
`timescale 1ns/100ps

module store_queue import lsq_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  except,
    input  logic                  commit,

    // new stores from dispatch
    sq_dispatch_if.queue          disp,

    // data broadcast
    input  logic     [ways-1:0]   cdb_valid,
    input  prf_tag_t [ways-1:0]   cdb_tag,
    input  data_t    [ways-1:0]   cdb_data,

    // address results
    input  logic     [ways-1:0]   alu_valid,
    input  rob_idx_t [ways-1:0]   alu_rob_idx,
    input  addr_t    [ways-1:0]   alu_addr,

    // retiring store to the data cache
    dcache_write_if.queue         wr,

    output sq_count_t             num_free,
    output sq_ptr_t               sq_head,
    output sq_ptr_t               sq_tail
);

    sq_entry_t entries      [sq_entries];
    sq_entry_t entries_next [sq_entries];

    logic [sq_entries-1:0][ways-1:0] cdb_hit;
    logic [sq_entries-1:0][ways-1:0] alu_hit;

    sq_count_t num_enq;

    always_comb begin
        num_enq = '0;
        for (int l = 0; l < ways; l++) begin
            num_enq = num_enq + sq_count_t'(disp.enable[l]);
        end
    end

    // tag and rob index compares, only for entries still waiting
    always_comb begin
        for (int e = 0; e < sq_entries; e++) begin
            for (int l = 0; l < ways; l++) begin
                cdb_hit[e][l] = entries[e].valid && !entries[e].data_valid &&
                                cdb_valid[l] && cdb_tag[l] == entries[e].tag;
                alu_hit[e][l] = entries[e].valid && !entries[e].addr_valid &&
                                alu_valid[l] && alu_rob_idx[l] == entries[e].rob_idx;
            end
        end
    end

    always_comb begin
        sq_ptr_t slot;
        entries_next = entries;

        // wakeups
        for (int e = 0; e < sq_entries; e++) begin
            for (int l = 0; l < ways; l++) begin
                if (cdb_hit[e][l]) begin
                    entries_next[e].data       = cdb_data[l];
                    entries_next[e].data_valid = 1'b1;
                end
                if (alu_hit[e][l]) begin
                    entries_next[e].addr       = alu_addr[l];
                    entries_next[e].addr_valid = 1'b1;
                end
            end
        end

        // head leaves on commit
        if (commit) begin
            entries_next[sq_head].valid = 1'b0;
        end

        // append at tail in lane order
        for (int l = 0; l < ways; l++) begin
            slot = sq_tail + sq_ptr_t'(l);
            if (disp.enable[l]) begin
                entries_next[slot] = '{
                    valid:      1'b1,
                    size:       disp.size[l],
                    rob_idx:    disp.rob_idx[l],
                    tag:        disp.tag[l],
                    data:       disp.data[l],
                    data_valid: disp.data_valid[l],
                    addr:       '0,
                    addr_valid: 1'b0
                };
            end
        end
    end

    // flag bits cleared, payload left as is
    always_ff @(posedge clock) begin
        if (reset || except) begin
            for (int e = 0; e < sq_entries; e++) begin
                entries[e].valid      <= 1'b0;
                entries[e].data_valid <= 1'b0;
                entries[e].addr_valid <= 1'b0;
            end
        end else begin
            entries <= entries_next;
        end
    end

    // pointers wrap at 8 by width
    always_ff @(posedge clock) begin
        if (reset || except) begin
            sq_head  <= '0;
            sq_tail  <= '0;
            num_free <= sq_count_t'(sq_entries);
        end else begin
            sq_head  <= sq_head + sq_ptr_t'(commit);
            sq_tail  <= sq_tail + sq_ptr_t'(num_enq);
            num_free <= num_free - num_enq + sq_count_t'(commit);
        end
    end

    // write stage, a committed store finishes even across a flush
    always_ff @(posedge clock) begin
        if (reset) begin
            wr.en <= 1'b0;
        end else begin
            wr.en <= commit;
        end
    end

    always_ff @(posedge clock) begin
        if (commit) begin
            wr.addr <= entries[sq_head].addr;
            wr.data <= entries[sq_head].data;
            wr.size <= entries[sq_head].size;
        end
    end

endmodule

/* rtl/store_write_mem.sv */
`timescale 1ns/100ps

module store_write_mem import lsq_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    dcache_write_if.mem   wr,
    input  addr_t         read_addr,
    output data_t         read_data
);

    logic [7:0] mem [mem_bytes];

    // request stage
    logic      req_en;
    mem_idx_t  req_addr;
    data_t     req_data;
    mem_size_t req_size;
    logic [7:0] byte_mask;

    always_ff @(posedge clock) begin
        if (reset) begin
            req_en <= 1'b0;
        end else begin
            req_en <= wr.en;
        end
    end

    always_ff @(posedge clock) begin
        if (wr.en) begin
            req_addr <= mem_idx_t'(wr.addr);
            req_data <= wr.data;
            req_size <= wr.size;
        end
    end

    // low-order bytes taken by size
    always_comb begin
        case (req_size)
            size_byte:   byte_mask = 8'h01;
            size_half:   byte_mask = 8'h03;
            size_word:   byte_mask = 8'h0f;
            size_double: byte_mask = 8'hff;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mem_bytes; i++) begin
                mem[i] <= '0;
            end
        end else if (req_en) begin
            for (int b = 0; b < 8; b++) begin
                if (byte_mask[b]) begin
                    mem[req_addr + mem_idx_t'(b)] <= req_data[b*8 +: 8];
                end
            end
        end
    end

    // little-endian read, wraps past the top byte
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            read_data[b*8 +: 8] = mem[mem_idx_t'(read_addr) + mem_idx_t'(b)];
        end
    end

endmodule

/* rtl/lsq_top.sv */
`timescale 1ns/100ps

module lsq_top import lsq_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,

    // store requests
    input  logic      [ways-1:0]  req_valid,
    input  mem_size_t [ways-1:0]  req_size,
    input  rob_idx_t  [ways-1:0]  req_rob_idx,
    input  prf_tag_t  [ways-1:0]  req_tag,
    input  data_t     [ways-1:0]  req_data,
    input  logic      [ways-1:0]  req_data_ready,

    // common data bus
    input  logic      [ways-1:0]  cdb_valid,
    input  prf_tag_t  [ways-1:0]  cdb_tag,
    input  data_t     [ways-1:0]  cdb_data,

    // address alu
    input  logic      [ways-1:0]  alu_valid,
    input  rob_idx_t  [ways-1:0]  alu_rob_idx,
    input  addr_t     [ways-1:0]  alu_addr,

    input  logic                  commit,
    input  logic                  except,

    output logic                  stall,
    output sq_count_t             num_free,
    output sq_ptr_t               sq_head,
    output sq_ptr_t               sq_tail,

    // memory inspection
    input  addr_t                 read_addr,
    output data_t                 read_data
);

    sq_dispatch_if  disp_if ();
    dcache_write_if wr_if ();

    store_dispatch dispatch_i (
        .req_valid      (req_valid),
        .req_size       (req_size),
        .req_rob_idx    (req_rob_idx),
        .req_tag        (req_tag),
        .req_data       (req_data),
        .req_data_ready (req_data_ready),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .num_free       (num_free),
        .stall          (stall),
        .disp           (disp_if.dispatch)
    );

    store_queue queue_i (
        .clock       (clock),
        .reset       (reset),
        .except      (except),
        .commit      (commit),
        .disp        (disp_if.queue),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_data    (cdb_data),
        .alu_valid   (alu_valid),
        .alu_rob_idx (alu_rob_idx),
        .alu_addr    (alu_addr),
        .wr          (wr_if.queue),
        .num_free    (num_free),
        .sq_head     (sq_head),
        .sq_tail     (sq_tail)
    );

    store_write_mem mem_i (
        .clock     (clock),
        .reset     (reset),
        .wr        (wr_if.mem),
        .read_addr (read_addr),
        .read_data (read_data)
    );

endmodule

/* dv/lsq_props.sv */
`timescale 1ns/100ps

module lsq_props import lsq_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      commit,
    input  sq_entry_t head_entry,
    input  sq_count_t num_free,
    input  logic      wr_en
);

    // the head store must be complete before it retires
    commit_ready: assert property (@(posedge clock) disable iff (reset)
        commit |-> head_entry.valid && head_entry.data_valid && head_entry.addr_valid)
        else $error("commit while the head entry lacks data or address");

    free_bound: assert property (@(posedge clock)
        num_free <= sq_count_t'(sq_entries))
        else $error("free count above queue size");

    wr_quiet_after_reset: assert property (@(posedge clock)
        reset |=> !wr_en)
        else $error("write enable high right after reset");

endmodule

bind store_queue lsq_props props_i (
    .clock      (clock),
    .reset      (reset),
    .commit     (commit),
    .head_entry (entries[sq_head]),
    .num_free   (num_free),
    .wr_en      (wr.en)
);

/* dv/lsq_tb.sv */
`timescale 1ns/100ps

module lsq_tb import lsq_pkg::*; ();

    logic clock;
    logic reset;
    logic      [ways-1:0] req_valid;
    mem_size_t [ways-1:0] req_size;
    rob_idx_t  [ways-1:0] req_rob_idx;
    prf_tag_t  [ways-1:0] req_tag;
    data_t     [ways-1:0] req_data;
    logic      [ways-1:0] req_data_ready;
    logic      [ways-1:0] cdb_valid;
    prf_tag_t  [ways-1:0] cdb_tag;
    data_t     [ways-1:0] cdb_data;
    logic      [ways-1:0] alu_valid;
    rob_idx_t  [ways-1:0] alu_rob_idx;
    addr_t     [ways-1:0] alu_addr;
    logic      commit;
    logic      except;
    logic      stall;
    sq_count_t num_free;
    sq_ptr_t   sq_head;
    sq_ptr_t   sq_tail;
    addr_t     read_addr;
    data_t     read_data;

    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_errors = 0;
    int cycles = 0;
    int limit = 0;

    // expected queue pointers and occupancy
    int exp_head = 0;
    int exp_tail = 0;
    int exp_used = 0;

    lsq_top lsq_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // run guard, sized from the tests file
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: tests did not finish");
            $display("sim failed");
            $finish;
        end
    end

    task automatic drive_idle();
        req_valid      <= '0;
        req_size       <= '0;
        req_rob_idx    <= '0;
        req_tag        <= '0;
        req_data       <= '0;
        req_data_ready <= '0;
        cdb_valid      <= '0;
        cdb_tag        <= '0;
        cdb_data       <= '0;
        alu_valid      <= '0;
        alu_rob_idx    <= '0;
        alu_addr       <= '0;
        commit         <= 1'b0;
        except         <= 1'b0;
    endtask

    // a group is taken whole only when it fits in the free entries
    task automatic accept_stores(input int n);
        if (n <= sq_entries - exp_used) begin
            exp_tail = (exp_tail + n) % sq_entries;
            exp_used = exp_used + n;
        end
    endtask

    task automatic check_value(input string test, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("error %s expected %h actual %h", test, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string test);
        tests++;
        $display("test %s finished with %0d errors", test, test_errors);
        test_errors = 0;
    endtask

    initial begin
        int fd;
        int lines;
        string line;
        string name;
        string op;
        string prev;
        logic [63:0] f [12];

        reset     <= 1'b1;
        read_addr <= '0;
        drive_idle();
        prev = "";

        // first pass only counts lines for the run guard
        lines = 0;
        fd = $fopen("dv/lsq_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/lsq_tests.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                lines++;
            end
            $fclose(fd);
            limit = 8 * lines + 100;
            fd = $fopen("dv/lsq_tests.txt", "r");
        end

        repeat (2) @(posedge clock);
        reset <= 1'b0;

        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (line.len() < 3 || line[0] == "#") begin
                continue;
            end
            foreach (f[k]) begin
                f[k] = '0;
            end
            void'($sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h", name, op,
                          f[0], f[1], f[2], f[3], f[4], f[5],
                          f[6], f[7], f[8], f[9], f[10], f[11]));
            if (prev != "" && name != prev) begin
                finish_test(prev);
            end
            prev = name;

            @(posedge clock);
            drive_idle();
            if (op == "dispatch" || op == "dispcdb") begin
                for (int l = 0; l < ways; l++) begin
                    req_valid[l]      <= f[6*l][0];
                    req_size[l]       <= mem_size_t'(f[6*l+1]);
                    req_rob_idx[l]    <= rob_idx_t'(f[6*l+2]);
                    req_tag[l]        <= prf_tag_t'(f[6*l+3]);
                    req_data[l]       <= f[6*l+4];
                    req_data_ready[l] <= f[6*l+5][0];
                end
                if (op == "dispcdb") begin
                    // lane 1 fields carry the broadcast instead
                    req_valid[1]   <= 1'b0;
                    cdb_valid[0]   <= 1'b1;
                    cdb_tag[0]     <= prf_tag_t'(f[6]);
                    cdb_data[0]    <= f[7];
                    accept_stores(int'(f[0][0]));
                end else begin
                    accept_stores(int'(f[0][0]) + int'(f[6][0]));
                end
            end else if (op == "cdb") begin
                cdb_valid[0] <= 1'b1;
                cdb_tag[0]   <= prf_tag_t'(f[0]);
                cdb_data[0]  <= f[1];
            end else if (op == "alu") begin
                alu_valid   <= {f[2][0], 1'b1};
                alu_rob_idx <= {rob_idx_t'(f[3]), rob_idx_t'(f[0])};
                alu_addr    <= {addr_t'(f[4]), addr_t'(f[1])};
            end else if (op == "commit") begin
                commit <= 1'b1;
                exp_head = (exp_head + 1) % sq_entries;
                exp_used = exp_used - 1;
            end else if (op == "except") begin
                except <= 1'b1;
                exp_head = 0;
                exp_tail = 0;
                exp_used = 0;
            end else if (op == "check_free") begin
                @(negedge clock);
                check_value(name, f[0], 64'(num_free));
                check_value(name, 64'(exp_head), 64'(sq_head));
                check_value(name, 64'(exp_tail), 64'(sq_tail));
            end else if (op == "check_stall") begin
                req_valid      <= {f[1][0], f[0][0]};
                req_size       <= '0;
                req_rob_idx    <= {rob_idx_t'(5'h1f), rob_idx_t'(5'h1e)};
                req_tag        <= {prf_tag_t'(6'h3f), prf_tag_t'(6'h3e)};
                req_data_ready <= '1;
                // the pair stays on the bus until the next edge
                accept_stores(int'(f[0][0]) + int'(f[1][0]));
                @(negedge clock);
                check_value(name, f[2], 64'(stall));
            end else if (op == "check_mem") begin
                read_addr <= addr_t'(f[0]);
                // commit to memory takes two more edges
                repeat (2) @(posedge clock);
                @(negedge clock);
                check_value(name, f[1], read_data);
            end else if (op != "idle") begin
                $display("unknown operation %s in test %s", op, name);
                errors++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (prev != "") begin
            finish_test(prev);
        end
        @(posedge clock);
        drive_idle();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* dv/lsq_tests.txt */
# name op fields in hex; dispatch: valid size rob tag data ready, lane 0 then lane 1
# cdb: tag data; alu: rob addr [lane1_valid rob addr]; check_mem: addr value; check_stall: v0 v1 stall
basic dispatch 1 2 01 01 deadbeef11223344 1 1 0 02 02 77665544332211ab 1
basic check_free 6
basic alu 01 10 1 02 16
basic commit
basic commit
basic check_mem 10 00ab000011223344
basic check_free 8
wakeup dispatch 1 1 03 05 0 0
wakeup cdb 06 9999
wakeup cdb 05 1234beef
wakeup alu 03 20
wakeup commit
wakeup check_mem 20 000000000000beef
bypass dispcdb 1 3 04 07 0 0 07 0123456789abcdef
bypass alu 04 30
bypass commit
bypass check_mem 30 0123456789abcdef
wrap dispatch 1 0 10 20 01 1 1 0 11 21 02 1
wrap dispatch 1 0 12 22 03 1 1 0 13 23 04 1
wrap dispatch 1 0 14 24 05 1 1 0 15 25 06 1
wrap alu 10 40 1 11 41
wrap alu 12 42 1 13 43
wrap alu 14 44 1 15 45
wrap commit
wrap commit
wrap commit
wrap commit
wrap commit
wrap commit
wrap check_mem 40 0000060504030201
wrap check_free 8
stall dispatch 1 0 08 30 0 1 1 0 09 31 0 1
stall dispatch 1 0 0a 32 0 1 1 0 0b 33 0 1
stall dispatch 1 0 0c 34 0 1 1 0 0d 35 0 1
stall dispatch 1 0 0e 36 0 1
stall check_free 1
stall check_stall 1 1 1
stall check_free 1
stall check_stall 1 0 0
stall check_free 0
flush alu 08 10
flush except
flush check_free 8
flush check_mem 10 00ab000011223344

/* tb.f */
common/lsq_pkg.sv
common/sq_dispatch_if.sv
common/dcache_write_if.sv
rtl/store_dispatch.sv
store_queue/store_queue.sv
rtl/store_write_mem.sv
rtl/lsq_top.sv
dv/lsq_props.sv
dv/lsq_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module lsq_tb -o lsq_sim
./obj_dir/lsq_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim passed" sim.log; then
    exit 0
else
    exit 1
fi
